/* src/rv32_int_config.svh */
// Width and count macros for the RV32I integer pipeline
`ifndef RV32_INT_CONFIG_SVH
`define RV32_INT_CONFIG_SVH

// Data word width
`define RV_XLEN 32

// Register index width
`define RV_REG_IDX_W 5

// Architectural register count
`define RV_REG_COUNT 32

// Shift amount width taken from operand 2
`define RV_SHAMT_W 5

`endif

/* src/rv32_int_pkg.sv */
// Opcode, ALU operation, operand source and immediate format enums
package rv32_int_pkg;

    // Major opcode, instruction bits 6 to 2
    // Anything not listed here decodes as illegal
    typedef enum logic [4:0] {
        // Register-register ALU ops
        OPCODE_OP     = 5'b01100,
        // Register-immediate ALU ops
        OPCODE_OP_IMM = 5'b00100,
        // Load upper immediate
        OPCODE_LUI    = 5'b01101,
        // Add upper immediate to pc
        OPCODE_AUIPC  = 5'b00101
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_OP_ADD  = 4'd0,
        ALU_OP_SUB  = 4'd1,
        // Logical left shift
        ALU_OP_SLL  = 4'd2,
        // Signed less-than
        ALU_OP_SLT  = 4'd3,
        // Unsigned less-than
        ALU_OP_SLTU = 4'd4,
        ALU_OP_XOR  = 4'd5,
        // Logical right shift
        ALU_OP_SRL  = 4'd6,
        // Arithmetic right shift
        ALU_OP_SRA  = 4'd7,
        ALU_OP_OR   = 4'd8,
        ALU_OP_AND  = 4'd9
    } alu_op_e;

    // First ALU operand source
    typedef enum logic [1:0] {
        // Register rs1 after forwarding
        OP1_SRC_RS1  = 2'd0,
        // Instruction pc, for AUIPC
        OP1_SRC_PC   = 2'd1,
        // Constant zero, for LUI
        OP1_SRC_ZERO = 2'd2
    } op1_src_e;

    // Second ALU operand source
    typedef enum logic [0:0] {
        // Register rs2 after forwarding
        OP2_SRC_RS2 = 1'b0,
        // Decoded immediate
        OP2_SRC_IMM = 1'b1
    } op2_src_e;

    // Immediate format
    // Only I and U survive in this subset
    typedef enum logic [1:0] {
        // No immediate, value forced to zero
        IMM_FORMAT_NONE = 2'd0,
        // Sign-extended bits 31 to 20
        IMM_FORMAT_I    = 2'd1,
        // Bits 31 to 12 with low bits zero
        IMM_FORMAT_U    = 2'd2
    } imm_format_e;

endpackage

/* src/decode_stage.sv */
// Decode stage with input flops, immediate generation and control decode
`timescale 1ns/1ns
`include "rv32_int_config.svh"

module decode_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    // Fetch side
    input  logic                       instr_valid,
    input  logic [31:0]                instr,
    input  logic [`RV_XLEN-1:0]        pc,
    // Hazard levels
    input  logic                       stall,
    input  logic                       flush,
    // Register file read ports
    output logic [`RV_REG_IDX_W-1:0]   rs1_idx,
    output logic [`RV_REG_IDX_W-1:0]   rs2_idx,
    input  logic [`RV_XLEN-1:0]        rs1_val,
    input  logic [`RV_XLEN-1:0]        rs2_val,
    // To execute
    output logic                       d_valid,
    output logic [`RV_XLEN-1:0]        d_pc,
    output logic [`RV_REG_IDX_W-1:0]   d_rd_idx,
    output logic                       d_rd_we,
    output logic [`RV_REG_IDX_W-1:0]   d_rs1_idx,
    output logic [`RV_REG_IDX_W-1:0]   d_rs2_idx,
    output logic [`RV_XLEN-1:0]        d_rs1_val,
    output logic [`RV_XLEN-1:0]        d_rs2_val,
    output logic [`RV_XLEN-1:0]        d_imm,
    output rv32_int_pkg::op1_src_e     d_op1_src,
    output rv32_int_pkg::op2_src_e     d_op2_src,
    output rv32_int_pkg::alu_op_e      d_alu_op,
    output logic                       d_illegal
);

    logic                          ff_valid;
    logic [31:0]                   ff_instr;
    logic [`RV_XLEN-1:0]           ff_pc;
    rv32_int_pkg::opcode_e         opcode;
    logic [2:0]                    funct3;
    logic                          funct7_b5;
    logic [`RV_REG_IDX_W-1:0]      rd_idx;
    rv32_int_pkg::imm_format_e     imm_format;
    logic [`RV_XLEN-1:0]           imm;
    logic                          legal;

    // Valid flop, holds while stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_valid <= 1'b0;
        end else if (!stall) begin
            ff_valid <= instr_valid;
        end
    end

    // Payload flops
    always_ff @(posedge clk) begin
        if (!stall) begin
            ff_instr <= instr;
            ff_pc    <= pc;
        end
    end

    // Flush drops the held instruction, stall delays it
    assign d_valid = ff_valid && !stall && !flush;

    // Field extraction
    assign opcode    = rv32_int_pkg::opcode_e'(ff_instr[6:2]);
    assign funct3    = ff_instr[14:12];
    assign funct7_b5 = ff_instr[30];
    assign rd_idx    = ff_instr[11:7];
    assign rs1_idx   = ff_instr[19:15];
    assign rs2_idx   = ff_instr[24:20];

    // Immediate format from opcode
    always_comb begin
        case (opcode)
            rv32_int_pkg::OPCODE_OP_IMM: imm_format = rv32_int_pkg::IMM_FORMAT_I;
            rv32_int_pkg::OPCODE_LUI,
            rv32_int_pkg::OPCODE_AUIPC:  imm_format = rv32_int_pkg::IMM_FORMAT_U;
            default:                     imm_format = rv32_int_pkg::IMM_FORMAT_NONE;
        endcase
    end

    always_comb begin
        case (imm_format)
            rv32_int_pkg::IMM_FORMAT_I: imm = {{20{ff_instr[31]}}, ff_instr[31:20]};
            rv32_int_pkg::IMM_FORMAT_U: imm = {ff_instr[31:12], 12'b0};
            default:                    imm = '0;
        endcase
    end

    // Control decode
    always_comb begin
        legal     = ff_instr[1:0] == 2'b11;
        d_op1_src = rv32_int_pkg::OP1_SRC_RS1;
        d_op2_src = rv32_int_pkg::OP2_SRC_RS2;
        d_alu_op  = rv32_int_pkg::ALU_OP_ADD;
        case (opcode)
            rv32_int_pkg::OPCODE_OP,
            rv32_int_pkg::OPCODE_OP_IMM: begin
                if (opcode == rv32_int_pkg::OPCODE_OP_IMM) begin
                    d_op2_src = rv32_int_pkg::OP2_SRC_IMM;
                end
                case (funct3)
                    // SUB only exists in the register form
                    3'b000: d_alu_op = (funct7_b5 && opcode == rv32_int_pkg::OPCODE_OP) ?
                                       rv32_int_pkg::ALU_OP_SUB : rv32_int_pkg::ALU_OP_ADD;
                    3'b001: d_alu_op = rv32_int_pkg::ALU_OP_SLL;
                    3'b010: d_alu_op = rv32_int_pkg::ALU_OP_SLT;
                    3'b011: d_alu_op = rv32_int_pkg::ALU_OP_SLTU;
                    3'b100: d_alu_op = rv32_int_pkg::ALU_OP_XOR;
                    3'b101: d_alu_op = funct7_b5 ? rv32_int_pkg::ALU_OP_SRA :
                                                   rv32_int_pkg::ALU_OP_SRL;
                    3'b110: d_alu_op = rv32_int_pkg::ALU_OP_OR;
                    default: d_alu_op = rv32_int_pkg::ALU_OP_AND;
                endcase
            end
            rv32_int_pkg::OPCODE_LUI: begin
                d_op1_src = rv32_int_pkg::OP1_SRC_ZERO;
                d_op2_src = rv32_int_pkg::OP2_SRC_IMM;
            end
            rv32_int_pkg::OPCODE_AUIPC: begin
                d_op1_src = rv32_int_pkg::OP1_SRC_PC;
                d_op2_src = rv32_int_pkg::OP2_SRC_IMM;
            end
            default: legal = 1'b0;
        endcase
    end

    // Outputs to execute
    // Writes to x0 are suppressed here so forwarding never matches x0
    assign d_rd_we   = legal && (rd_idx != '0);
    assign d_illegal = !legal;
    assign d_pc      = ff_pc;
    assign d_rd_idx  = rd_idx;
    assign d_rs1_idx = rs1_idx;
    assign d_rs2_idx = rs2_idx;
    assign d_rs1_val = rs1_val;
    assign d_rs2_val = rs2_val;
    assign d_imm     = imm;

endmodule

/* src/execute_stage.sv */
// Execute stage with decode register, operand forwarding and ALU
`timescale 1ns/1ns
`include "rv32_int_config.svh"

module execute_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    // From decode
    input  logic                       d_valid,
    input  logic [`RV_XLEN-1:0]        d_pc,
    input  logic [`RV_REG_IDX_W-1:0]   d_rd_idx,
    input  logic                       d_rd_we,
    input  logic [`RV_REG_IDX_W-1:0]   d_rs1_idx,
    input  logic [`RV_REG_IDX_W-1:0]   d_rs2_idx,
    input  logic [`RV_XLEN-1:0]        d_rs1_val,
    input  logic [`RV_XLEN-1:0]        d_rs2_val,
    input  logic [`RV_XLEN-1:0]        d_imm,
    input  rv32_int_pkg::op1_src_e     d_op1_src,
    input  rv32_int_pkg::op2_src_e     d_op2_src,
    input  rv32_int_pkg::alu_op_e      d_alu_op,
    input  logic                       d_illegal,
    // Forwarding from result
    input  logic                       wb_we,
    input  logic [`RV_REG_IDX_W-1:0]   wb_rd_idx,
    input  logic [`RV_XLEN-1:0]        wb_data,
    // To result
    output logic                       e_valid,
    output logic [`RV_XLEN-1:0]        e_pc,
    output logic [`RV_REG_IDX_W-1:0]   e_rd_idx,
    output logic                       e_rd_we,
    output logic [`RV_XLEN-1:0]        e_result,
    output logic                       e_illegal
);

    logic [`RV_REG_IDX_W-1:0]   ex_rs1_idx;
    logic [`RV_REG_IDX_W-1:0]   ex_rs2_idx;
    logic [`RV_XLEN-1:0]        ex_rs1_val;
    logic [`RV_XLEN-1:0]        ex_rs2_val;
    logic [`RV_XLEN-1:0]        ex_imm;
    rv32_int_pkg::op1_src_e     ex_op1_src;
    rv32_int_pkg::op2_src_e     ex_op2_src;
    rv32_int_pkg::alu_op_e      ex_alu_op;
    logic [`RV_XLEN-1:0]        fwd_rs1;
    logic [`RV_XLEN-1:0]        fwd_rs2;
    logic [`RV_XLEN-1:0]        op1;
    logic [`RV_XLEN-1:0]        op2;
    logic [`RV_SHAMT_W-1:0]     shamt;

    // Valid bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= d_valid;
        end
    end

    // Payload, qualified by e_valid downstream
    always_ff @(posedge clk) begin
        e_pc       <= d_pc;
        e_rd_idx   <= d_rd_idx;
        e_rd_we    <= d_rd_we;
        e_illegal  <= d_illegal;
        ex_rs1_idx <= d_rs1_idx;
        ex_rs2_idx <= d_rs2_idx;
        ex_rs1_val <= d_rs1_val;
        ex_rs2_val <= d_rs2_val;
        ex_imm     <= d_imm;
        ex_op1_src <= d_op1_src;
        ex_op2_src <= d_op2_src;
        ex_alu_op  <= d_alu_op;
    end

    // Previous instruction's result bypasses the stale register file read
    assign fwd_rs1 = (wb_we && wb_rd_idx == ex_rs1_idx) ? wb_data : ex_rs1_val;
    assign fwd_rs2 = (wb_we && wb_rd_idx == ex_rs2_idx) ? wb_data : ex_rs2_val;

    // Operand selection
    always_comb begin
        case (ex_op1_src)
            rv32_int_pkg::OP1_SRC_PC:   op1 = e_pc;
            rv32_int_pkg::OP1_SRC_ZERO: op1 = '0;
            default:                    op1 = fwd_rs1;
        endcase
        op2 = (ex_op2_src == rv32_int_pkg::OP2_SRC_IMM) ? ex_imm : fwd_rs2;
    end

    assign shamt = op2[`RV_SHAMT_W-1:0];

    // ALU
    always_comb begin
        case (ex_alu_op)
            rv32_int_pkg::ALU_OP_SUB:  e_result = op1 - op2;
            rv32_int_pkg::ALU_OP_SLL:  e_result = op1 << shamt;
            rv32_int_pkg::ALU_OP_SLT:  e_result = {31'b0, $signed(op1) < $signed(op2)};
            rv32_int_pkg::ALU_OP_SLTU: e_result = {31'b0, op1 < op2};
            rv32_int_pkg::ALU_OP_XOR:  e_result = op1 ^ op2;
            rv32_int_pkg::ALU_OP_SRL:  e_result = op1 >> shamt;
            rv32_int_pkg::ALU_OP_SRA:  e_result = $signed(op1) >>> shamt;
            rv32_int_pkg::ALU_OP_OR:   e_result = op1 | op2;
            rv32_int_pkg::ALU_OP_AND:  e_result = op1 & op2;
            default:                   e_result = op1 + op2;
        endcase
    end

endmodule

/* src/result_stage.sv */
// Result stage with retirement register and 32-entry register file
`timescale 1ns/1ns
`include "rv32_int_config.svh"

module result_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    // From execute
    input  logic                       e_valid,
    input  logic [`RV_XLEN-1:0]        e_pc,
    input  logic [`RV_REG_IDX_W-1:0]   e_rd_idx,
    input  logic                       e_rd_we,
    input  logic [`RV_XLEN-1:0]        e_result,
    input  logic                       e_illegal,
    // Read ports for decode
    input  logic [`RV_REG_IDX_W-1:0]   rs1_idx,
    input  logic [`RV_REG_IDX_W-1:0]   rs2_idx,
    output logic [`RV_XLEN-1:0]        rs1_val,
    output logic [`RV_XLEN-1:0]        rs2_val,
    // Retirement
    output logic                       wb_valid,
    output logic [`RV_XLEN-1:0]        wb_pc,
    output logic [`RV_REG_IDX_W-1:0]   wb_rd_idx,
    output logic                       wb_we,
    output logic [`RV_XLEN-1:0]        wb_data,
    output logic                       wb_illegal
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // Retirement control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= e_valid;
            wb_we    <= e_valid && e_rd_we;
        end
    end

    // Retirement payload
    always_ff @(posedge clk) begin
        wb_pc      <= e_pc;
        wb_rd_idx  <= e_rd_idx;
        wb_data    <= e_result;
        wb_illegal <= e_illegal;
    end

    // Register file, written on the same edge as the retirement register
    // x0 stays zero since decode never enables a write to it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (e_valid && e_rd_we) begin
            regs[e_rd_idx] <= e_result;
        end
    end

    // Combinational reads
    assign rs1_val = regs[rs1_idx];
    assign rs2_val = regs[rs2_idx];

endmodule

/* src/rv32_int_pipe.sv */
// Top level connecting decode, execute and result stages
`timescale 1ns/1ns
`include "rv32_int_config.svh"

module rv32_int_pipe (
    input  logic                       clk,
    input  logic                       rst_n,
    // Instruction input
    input  logic                       instr_valid,
    input  logic [31:0]                instr,
    input  logic [`RV_XLEN-1:0]        pc,
    input  logic                       stall,
    input  logic                       flush,
    // Retirement report
    output logic                       wb_valid,
    output logic [`RV_XLEN-1:0]        wb_pc,
    output logic [`RV_REG_IDX_W-1:0]   wb_rd_idx,
    output logic                       wb_we,
    output logic [`RV_XLEN-1:0]        wb_data,
    output logic                       wb_illegal
);

    // Register file read path
    logic [`RV_REG_IDX_W-1:0]   rs1_idx;
    logic [`RV_REG_IDX_W-1:0]   rs2_idx;
    logic [`RV_XLEN-1:0]        rs1_val;
    logic [`RV_XLEN-1:0]        rs2_val;
    // Decode to execute
    logic                       d_valid;
    logic [`RV_XLEN-1:0]        d_pc;
    logic [`RV_REG_IDX_W-1:0]   d_rd_idx;
    logic                       d_rd_we;
    logic [`RV_REG_IDX_W-1:0]   d_rs1_idx;
    logic [`RV_REG_IDX_W-1:0]   d_rs2_idx;
    logic [`RV_XLEN-1:0]        d_rs1_val;
    logic [`RV_XLEN-1:0]        d_rs2_val;
    logic [`RV_XLEN-1:0]        d_imm;
    rv32_int_pkg::op1_src_e     d_op1_src;
    rv32_int_pkg::op2_src_e     d_op2_src;
    rv32_int_pkg::alu_op_e      d_alu_op;
    logic                       d_illegal;
    // Execute to result
    logic                       e_valid;
    logic [`RV_XLEN-1:0]        e_pc;
    logic [`RV_REG_IDX_W-1:0]   e_rd_idx;
    logic                       e_rd_we;
    logic [`RV_XLEN-1:0]        e_result;
    logic                       e_illegal;

    decode_stage i_decode_stage (.*);

    execute_stage i_execute_stage (.*);

    result_stage i_result_stage (.*);

endmodule

/* testbench/clock_gen.sv */
// Testbench clock and reset generator
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Reset low across the first three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* testbench/rv32_int_pipe_tb.sv */
// Testbench for the RV32I integer pipeline with reference model and retirement checker
`timescale 1ns/1ns
`include "rv32_int_config.svh"

module rv32_int_pipe_tb;

    // Instructions issued per test
    localparam int N_RESET   = 8;
    localparam int N_ALU     = 200;
    localparam int N_UPPER   = 40;
    localparam int N_X0      = 24;
    localparam int N_ILLEGAL = 32;
    localparam int N_HAZARD  = 120;
    localparam int N_TOTAL   = N_RESET + N_ALU + N_UPPER + N_X0 + N_ILLEGAL + N_HAZARD;
    localparam int CYCLE_LIMIT = 10 * N_TOTAL + 200;

    // One expected retirement
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] data;
        logic        illegal;
    } retire_t;

    logic                      clk;
    logic                      rst_n;
    logic                      instr_valid;
    logic [31:0]               instr;
    logic [`RV_XLEN-1:0]       pc;
    logic                      stall;
    logic                      flush;
    logic                      wb_valid;
    logic [`RV_XLEN-1:0]       wb_pc;
    logic [`RV_REG_IDX_W-1:0]  wb_rd_idx;
    logic                      wb_we;
    logic [`RV_XLEN-1:0]       wb_data;
    logic                      wb_illegal;

    logic [31:0] lfsr_state;
    logic [31:0] model_regs [32];
    logic [31:0] pc_next;
    retire_t     exp_q [$];
    string       test_name;
    int          error_count;
    int          check_count;
    int          test_errors_start;
    int          test_issued;
    int          issued_count;
    int          tests_run;
    int          cycle_count;

    clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv32_int_pipe i_rv32_int_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .stall       (stall),
        .flush       (flush),
        .wb_valid    (wb_valid),
        .wb_pc       (wb_pc),
        .wb_rd_idx   (wb_rd_idx),
        .wb_we       (wb_we),
        .wb_data     (wb_data),
        .wb_illegal  (wb_illegal)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // Random OP or OP_IMM, registers drawn from the low 2^reg_bits
    function automatic logic [31:0] make_alu_instr(input int reg_bits);
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        f3  = 3'(rand_bits(3));
        alt = 1'(rand_bits(1));
        rd  = 5'(rand_bits(reg_bits));
        rs1 = 5'(rand_bits(reg_bits));
        rs2 = 5'(rand_bits(reg_bits));
        imm = 12'(rand_bits(12));
        if (rand_bits(1) != 0) begin
            // funct7 bit 5 only meaningful for ADD/SUB and SRL/SRA
            if (f3 != 3'b000 && f3 != 3'b101) begin
                alt = 1'b0;
            end
            return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
        end
        // Shift immediates carry shamt plus the SRAI bit
        if (f3 == 3'b001 || f3 == 3'b101) begin
            imm = {1'b0, (f3 == 3'b101) ? alt : 1'b0, 5'b0, imm[4:0]};
        end
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] make_upper_instr();
        logic [19:0] imm;
        logic [4:0]  rd;
        logic        is_lui;
        imm    = 20'(rand_bits(20));
        rd     = 5'(rand_bits(5));
        is_lui = 1'(rand_bits(1));
        return {imm, rd, is_lui ? 7'b0110111 : 7'b0010111};
    endfunction

    // Either bad low bits or an opcode outside the kept set
    function automatic logic [31:0] make_illegal_instr();
        logic [31:0] word;
        logic [4:0]  op;
        word = rand_bits(32);
        if (rand_bits(1) != 0) begin
            word[1:0] = 2'(rand_bits(2));
            if (word[1:0] == 2'b11) begin
                word[1:0] = 2'b01;
            end
        end else begin
            op = 5'(rand_bits(5));
            // Top bit flip moves each kept opcode onto an unsupported one
            if (op == 5'b01100 || op == 5'b00100 || op == 5'b01101 || op == 5'b00101) begin
                op = op ^ 5'b10000;
            end
            word[6:2] = op;
            word[1:0] = 2'b11;
        end
        return word;
    endfunction

    // Reference model, RV32I semantics on the model register file
    function automatic retire_t ref_execute(input logic [31:0] word, input logic [31:0] addr);
        retire_t     result;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_u;
        logic [31:0] res;
        logic [4:0]  sh;
        logic        legal;
        a     = model_regs[word[19:15]];
        b     = model_regs[word[24:20]];
        imm_u = {word[31:12], 12'b0};
        legal = (word[1:0] == 2'b11);
        // OP_IMM takes the sign-extended I immediate as operand b
        if (word[6:2] == 5'b00100) begin
            b = {{20{word[31]}}, word[31:20]};
        end
        sh = b[4:0];
        case (word[14:12])
            3'b000:  res = (word[30] && word[6:2] == 5'b01100) ? a - b : a + b;
            3'b001:  res = a << sh;
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101: begin
                // Bit 30 picks the sign-filling shift
                if (word[30]) begin
                    res = $signed(a) >>> sh;
                end else begin
                    res = a >> sh;
                end
            end
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        case (word[6:2])
            5'b01100, 5'b00100: ;
            5'b01101: res = imm_u;
            5'b00101: res = addr + imm_u;
            default:  legal = 1'b0;
        endcase
        result.pc      = addr;
        result.rd      = word[11:7];
        result.we      = legal && (word[11:7] != 5'd0);
        result.data    = res;
        result.illegal = !legal;
        if (result.we) begin
            model_regs[word[11:7]] = res;
        end
        return result;
    endfunction

    task automatic compare_value(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, field, expected, actual);
            error_count++;
        end
    endtask

    // Drive one instruction, then optionally a flush cycle, a stall run or a gap
    task automatic issue(input logic [31:0] word, input logic [31:0] addr, input bit hazards);
        logic [1:0] choice;
        logic       flushed;
        int         stall_cycles;
        instr_valid = 1'b1;
        instr       = word;
        pc          = addr;
        @(posedge clk);
        #1;
        instr_valid  = 1'b0;
        flushed      = 1'b0;
        issued_count++;
        test_issued++;
        pc_next = addr + 32'd4;
        if (hazards) begin
            choice = 2'(rand_bits(2));
            if (choice == 2'd0) begin
                flushed = 1'b1;
                flush   = 1'b1;
                @(posedge clk);
                #1;
                flush = 1'b0;
            end else if (choice == 2'd1) begin
                stall_cycles = 1 + int'(rand_bits(2));
                stall        = 1'b1;
                repeat (stall_cycles) @(posedge clk);
                #1;
                stall = 1'b0;
            end else if (choice == 2'd2) begin
                @(posedge clk);
                #1;
            end
        end
        if (!flushed) begin
            exp_q.push_back(ref_execute(word, addr));
        end
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_errors_start = error_count;
        test_issued       = 0;
    endtask

    // Wait for outstanding retirements, then a few cycles to catch strays
    task automatic finish_test();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        repeat (3) @(posedge clk);
        #1;
        if (exp_q.size() != 0) begin
            $display("ERROR %s: %0d expected retirements never appeared", test_name, exp_q.size());
            error_count++;
            exp_q.delete();
        end
        $display("test %-12s issued %0d, errors %0d", test_name, test_issued,
                 error_count - test_errors_start);
        tests_run++;
    endtask

    // Retirement checker, samples away from the rising edge
    always @(negedge clk) begin
        retire_t expected;
        if (rst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR %s: retirement at pc %h with nothing outstanding", test_name, wb_pc);
                error_count++;
            end else begin
                expected = exp_q.pop_front();
                compare_value("pc", expected.pc, wb_pc);
                compare_value("rd", 32'(expected.rd), 32'(wb_rd_idx));
                compare_value("we", 32'(expected.we), 32'(wb_we));
                compare_value("illegal", 32'(expected.illegal), 32'(wb_illegal));
                // Data of an illegal instruction carries no meaning
                if (!expected.illegal) begin
                    compare_value("data", expected.data, wb_data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [31:0] word;
        lfsr_state  = 32'd66;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        pc_next     = 32'h0000_1000;
        error_count = 0;
        check_count = 0;
        issued_count = 0;
        tests_run   = 0;
        cycle_count = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        wait (rst_n == 1'b1);
        @(posedge clk);
        #1;

        // Idle first, any retirement here is flagged by the checker
        start_test("reset");
        repeat (5) @(posedge clk);
        #1;
        for (int n = 1; n <= N_RESET; n++) begin
            word = {7'b0, 5'(n + 16), 5'(n + 8), 3'b110, 5'(n), 7'b0110011};
            issue(word, pc_next, 1'b0);
        end
        finish_test();

        // Back to back over x0..x7, mixing forwarding and register file reads
        start_test("alu_ops");
        for (int n = 0; n < N_ALU; n++) begin
            issue(make_alu_instr(3), pc_next, 1'b0);
        end
        finish_test();

        start_test("upper_imm");
        for (int n = 0; n < N_UPPER; n++) begin
            issue(make_upper_instr(), rand_bits(32), 1'b0);
        end
        finish_test();

        // Write attempt to x0 followed at once by a read of x0
        start_test("x0_dest");
        for (int n = 0; n < N_X0 / 2; n++) begin
            if (rand_bits(1) != 0) begin
                word = {12'(rand_bits(12)), 5'(rand_bits(5)), 3'b000, 5'd0, 7'b0010011};
            end else begin
                word = {20'(rand_bits(20)), 5'd0, 7'b0110111};
            end
            issue(word, pc_next, 1'b0);
            word = {7'b0, 5'd0, 5'd0, 3'b000, 5'(rand_bits(5)), 7'b0110011};
            issue(word, pc_next, 1'b0);
        end
        finish_test();

        // Each illegal word is followed by a read of its rd field
        start_test("illegal");
        for (int n = 0; n < N_ILLEGAL / 2; n++) begin
            word = make_illegal_instr();
            issue(word, pc_next, 1'b0);
            word = {7'b0, 5'd0, word[11:7], 3'b000, 5'(rand_bits(5)), 7'b0110011};
            issue(word, pc_next, 1'b0);
        end
        finish_test();

        start_test("stall_flush");
        for (int n = 0; n < N_HAZARD; n++) begin
            case (2'(rand_bits(2)))
                2'd0, 2'd1: word = make_alu_instr(3);
                2'd2:       word = make_upper_instr();
                default:    word = make_illegal_instr();
            endcase
            issue(word, pc_next, 1'b1);
        end
        finish_test();

        $display("Tests %0d, instructions issued %0d, checks %0d, errors %0d",
                 tests_run, issued_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* rv32_int_pipe.f */
+incdir+src
src/rv32_int_pkg.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/rv32_int_pipe.sv
testbench/clock_gen.sv
testbench/rv32_int_pipe_tb.sv

/* Makefile */
# Verilator build and run of the RV32I integer pipeline testbench

TOP = rv32_int_pipe_tb

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f rv32_int_pipe.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
